/* hw/cpuPkg.sv */
package cpuPkg;

    localparam int wordWidth = 16;
    localparam int regAddrWidth = 2;
    localparam int numRegs = 1 << regAddrWidth;

    // Link instructions write their return address here
    localparam logic [regAddrWidth-1:0] linkReg = 2'd2;

    // Forwarding selects for the execute operands
    localparam logic [1:0] fwdReg = 2'd0;
    localparam logic [1:0] fwdMem = 2'd1;
    localparam logic [1:0] fwdWb = 2'd2;

    typedef enum logic [3:0] {
        opBne = 4'd0,
        opBeq = 4'd1,
        opBgz = 4'd2,
        opBlz = 4'd3,
        opAdi = 4'd4,
        opOri = 4'd5,
        opLhi = 4'd6,
        opLwd = 4'd7,
        opSwd = 4'd8,
        opJmp = 4'd9,
        opJal = 4'd10,
        opRtype = 4'd15
    } opcodeE;

    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOrr = 6'd3,
        fnNot = 6'd4,
        fnTcp = 6'd5,
        fnJpr = 6'd25,
        fnJrl = 6'd26,
        fnWwd = 6'd28,
        fnHlt = 6'd29
    } funcE;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNot,
        aluNeg,
        aluPassA,
        aluLhi
    } aluOpE;

    typedef struct packed {
        // Writeback
        logic isWwd;
        logic regWrite;
        logic memToReg;
        // Memory
        logic memWrite;
        logic memRead;
        // Execute
        logic isBranch;
        logic aluSrc;
        logic isJumpR;
        logic isJump;
        logic isLink;
        logic isHalt;
        // Decode
        logic regDst;
    } ctrlT;

endpackage

/* hw/hazardIf.sv */
`timescale 1ns/1ps

interface hazardIf;
    logic [cpuPkg::regAddrWidth-1:0] idRs;
    logic [cpuPkg::regAddrWidth-1:0] idRt;
    logic                            idUseRs;
    logic                            idUseRt;
    logic [cpuPkg::regAddrWidth-1:0] exRs;
    logic [cpuPkg::regAddrWidth-1:0] exRt;
    logic [cpuPkg::regAddrWidth-1:0] exRd;
    logic                            exMemRead;
    logic [cpuPkg::regAddrWidth-1:0] memRd;
    logic                            memRegWrite;
    logic [cpuPkg::regAddrWidth-1:0] wbRd;
    logic                            wbRegWrite;
    logic [1:0]                      forwardA;
    logic [1:0]                      forwardB;
    logic                            stall;

    modport datapath (
        output idRs, idRt, idUseRs, idUseRt, exRs, exRt, exRd, exMemRead,
        output memRd, memRegWrite, wbRd, wbRegWrite,
        input  forwardA, forwardB, stall
    );

    modport unit (
        input  idRs, idRt, idUseRs, idUseRt, exRs, exRt, exRd, exMemRead,
        input  memRd, memRegWrite, wbRd, wbRegWrite,
        output forwardA, forwardB, stall
    );
endinterface

/* hw/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                            Clk,
    input  logic                            arstN,
    input  logic [cpuPkg::regAddrWidth-1:0] rs,
    input  logic [cpuPkg::regAddrWidth-1:0] rt,
    input  logic [cpuPkg::regAddrWidth-1:0] rdW,
    input  logic [cpuPkg::wordWidth-1:0]    writeData,
    input  logic                            regWrite,
    output logic [cpuPkg::wordWidth-1:0]    readData1,
    output logic [cpuPkg::wordWidth-1:0]    readData2
);
    import cpuPkg::*;

    logic [wordWidth-1:0] regs [numRegs];

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite) begin
            regs[rdW] <= writeData;
        end
    end

    assign readData1 = regs[rs];
    assign readData2 = regs[rt];

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpuPkg::ctrlT                 ctrl,
    input  cpuPkg::opcodeE               opcode,
    input  cpuPkg::funcE                 func,
    input  logic [cpuPkg::wordWidth-1:0] operandA,
    input  logic [cpuPkg::wordWidth-1:0] operandB,
    output logic [cpuPkg::wordWidth-1:0] result,
    output logic                         branchTaken
);
    import cpuPkg::*;

    aluOpE aluOp;

    always_comb begin
        case (opcode)
            opAdi, opLwd, opSwd: aluOp = aluAdd;
            opOri: aluOp = aluOr;
            opLhi: aluOp = aluLhi;
            opBne, opBeq: aluOp = aluSub;
            opRtype: begin
                case (func)
                    fnAdd: aluOp = aluAdd;
                    fnSub: aluOp = aluSub;
                    fnAnd: aluOp = aluAnd;
                    fnOrr: aluOp = aluOr;
                    fnNot: aluOp = aluNot;
                    fnTcp: aluOp = aluNeg;
                    default: aluOp = aluPassA;
                endcase
            end
            // JAL and JRL get the return address on operand A
            default: aluOp = aluPassA;
        endcase
    end

    always_comb begin
        case (aluOp)
            aluAdd: result = operandA + operandB;
            aluSub: result = operandA - operandB;
            aluAnd: result = operandA & operandB;
            aluOr: result = operandA | operandB;
            aluNot: result = ~operandA;
            aluNeg: result = ~operandA + wordWidth'(1);
            aluLhi: result = {operandB[7:0], 8'h00};
            default: result = operandA;
        endcase
    end

    always_comb begin
        branchTaken = 1'b0;
        if (ctrl.isBranch) begin
            case (opcode)
                opBne: branchTaken = (operandA != operandB);
                opBeq: branchTaken = (operandA == operandB);
                opBgz: branchTaken = !operandA[wordWidth-1] && (operandA != '0);
                opBlz: branchTaken = operandA[wordWidth-1];
                default: branchTaken = 1'b0;
            endcase
        end
    end

endmodule

/* hw/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
    hazardIf.unit hz
);
    import cpuPkg::*;

    // Memory stage is younger, so it wins over writeback
    function automatic logic [1:0] fwdSelect(input logic [regAddrWidth-1:0] src);
        if (hz.memRegWrite && hz.memRd == src) begin
            return fwdMem;
        end
        if (hz.wbRegWrite && hz.wbRd == src) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    always_comb begin
        hz.forwardA = fwdSelect(hz.exRs);
        hz.forwardB = fwdSelect(hz.exRt);
    end

    // Load in execute feeding the instruction in decode
    assign hz.stall = hz.exMemRead
                      && ((hz.idUseRs && hz.idRs == hz.exRd)
                      || (hz.idUseRt && hz.idRt == hz.exRd));

endmodule

/* hw/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input  logic [cpuPkg::wordWidth-1:0] instr,
    input  logic                         decodeValid,
    output cpuPkg::ctrlT                 ctrl,
    output logic                         useRs,
    output logic                         useRt
);
    import cpuPkg::*;

    opcodeE opcode;
    funcE   func;
    logic   isRtype;

    assign opcode = opcodeE'(instr[15:12]);
    assign func = funcE'(instr[5:0]);
    assign isRtype = (opcode == opRtype);

    // Jumps, LHI and HLT read no register
    assign useRs = decodeValid && !(opcode inside {opJmp, opJal, opLhi})
                   && !(isRtype && func == fnHlt);
    assign useRt = decodeValid && ((opcode inside {opBne, opBeq, opSwd})
                   || (isRtype && func inside {fnAdd, fnSub, fnAnd, fnOrr}));

    always_comb begin
        ctrl = '0;
        if (decodeValid) begin
            case (opcode)
                opBne, opBeq, opBgz, opBlz: begin
                    ctrl.isBranch = 1'b1;
                end
                opAdi, opOri, opLhi: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc = 1'b1;
                end
                opLwd: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.memRead = 1'b1;
                    ctrl.aluSrc = 1'b1;
                end
                opSwd: begin
                    ctrl.memWrite = 1'b1;
                    ctrl.aluSrc = 1'b1;
                end
                opJmp: begin
                    ctrl.isJump = 1'b1;
                end
                opJal: begin
                    ctrl.isJump = 1'b1;
                    ctrl.isLink = 1'b1;
                    ctrl.regWrite = 1'b1;
                end
                opRtype: begin
                    case (func)
                        fnAdd, fnSub, fnAnd, fnOrr, fnNot, fnTcp: begin
                            ctrl.regWrite = 1'b1;
                            ctrl.regDst = 1'b1;
                        end
                        fnJpr: begin
                            ctrl.isJumpR = 1'b1;
                        end
                        fnJrl: begin
                            ctrl.isJumpR = 1'b1;
                            ctrl.isLink = 1'b1;
                            ctrl.regWrite = 1'b1;
                        end
                        fnWwd: ctrl.isWwd = 1'b1;
                        fnHlt: ctrl.isHalt = 1'b1;
                        default: ctrl = '0;
                    endcase
                end
                default: ctrl = '0;
            endcase
        end
    end

endmodule

/* hw/pipeDatapath.sv */
`timescale 1ns/1ps

module pipeDatapath (
    input  logic                         Clk,
    input  logic                         arstN,
    input  logic [cpuPkg::wordWidth-1:0] instData,
    input  logic [cpuPkg::wordWidth-1:0] dataRdata,
    input  cpuPkg::ctrlT                 ctrl,
    input  logic                         useRs,
    input  logic                         useRt,
    output logic [cpuPkg::wordWidth-1:0] instAddr,
    output logic                         instRead,
    output logic [cpuPkg::wordWidth-1:0] dataAddr,
    output logic                         dataRead,
    output logic                         dataWrite,
    output logic [cpuPkg::wordWidth-1:0] dataWdata,
    output logic [cpuPkg::wordWidth-1:0] decodeInstr,
    output logic                         decodeValid,
    output logic                         halted,
    output logic [cpuPkg::wordWidth-1:0] numInst,
    output logic [cpuPkg::wordWidth-1:0] outPort
);
    import cpuPkg::*;

    logic [wordWidth-1:0] pc;
    logic [wordWidth-1:0] pcPlus1;
    logic [wordWidth-1:0] nextPc;

    // Fetch/decode
    logic [wordWidth-1:0] fdInstr;
    logic [wordWidth-1:0] fdPcNext;
    logic                 fdValid;

    // Decode/execute
    ctrlT                    deCtrl;
    logic                    deValid;
    logic [wordWidth-1:0]    dePcNext;
    logic [wordWidth-1:0]    deRead1;
    logic [wordWidth-1:0]    deRead2;
    logic [wordWidth-1:0]    deImm;
    logic [regAddrWidth-1:0] deRs;
    logic [regAddrWidth-1:0] deRt;
    logic [regAddrWidth-1:0] deRd;
    opcodeE                  deOpcode;
    funcE                    deFunc;

    // Execute/memory
    ctrlT                    emCtrl;
    logic                    emValid;
    logic [wordWidth-1:0]    emAluOut;
    logic [wordWidth-1:0]    emStoreData;
    logic [regAddrWidth-1:0] emRd;

    // Memory/writeback
    ctrlT                    mwCtrl;
    logic                    mwValid;
    logic [wordWidth-1:0]    mwAluOut;
    logic [wordWidth-1:0]    mwReadData;
    logic [regAddrWidth-1:0] mwRd;

    opcodeE                  idOpcode;
    logic [regAddrWidth-1:0] idRs;
    logic [regAddrWidth-1:0] idRt;
    logic [regAddrWidth-1:0] idRd;
    logic [wordWidth-1:0]    idImm;
    logic [wordWidth-1:0]    rfRead1;
    logic [wordWidth-1:0]    rfRead2;
    logic [wordWidth-1:0]    idRead1;
    logic [wordWidth-1:0]    idRead2;
    logic [wordWidth-1:0]    jumpTarget;

    logic [wordWidth-1:0] fwdA;
    logic [wordWidth-1:0] fwdB;
    logic [wordWidth-1:0] aluInA;
    logic [wordWidth-1:0] aluInB;
    logic [wordWidth-1:0] aluResult;
    logic [wordWidth-1:0] branchTarget;
    logic [wordWidth-1:0] wbData;
    logic                 branchTaken;
    logic                 exBranch;
    logic                 exJumpR;
    logic                 idJump;
    logic                 stall;
    logic                 emHalt;
    logic                 retireHalt;

    hazardIf hzIf ();

    // Decode
    assign decodeInstr = fdInstr;
    assign decodeValid = fdValid;
    assign idOpcode = opcodeE'(fdInstr[15:12]);
    assign idRs = fdInstr[11:10];
    assign idRt = fdInstr[9:8];
    assign idRd = ctrl.isLink ? linkReg : (ctrl.regDst ? fdInstr[7:6] : fdInstr[9:8]);
    assign idImm = (idOpcode == opOri) ? {8'h00, fdInstr[7:0]}
                                       : {{8{fdInstr[7]}}, fdInstr[7:0]};
    assign jumpTarget = {fdPcNext[15:12], fdInstr[11:0]};

    // Register written back this cycle is not yet visible in the file
    assign idRead1 = (mwCtrl.regWrite && mwRd == idRs) ? wbData : rfRead1;
    assign idRead2 = (mwCtrl.regWrite && mwRd == idRt) ? wbData : rfRead2;

    regFile u_regFile (
        .Clk      (Clk),
        .arstN    (arstN),
        .rs       (idRs),
        .rt       (idRt),
        .rdW      (mwRd),
        .writeData(wbData),
        .regWrite (mwCtrl.regWrite),
        .readData1(rfRead1),
        .readData2(rfRead2)
    );

    assign hzIf.idRs = idRs;
    assign hzIf.idRt = idRt;
    assign hzIf.idUseRs = useRs;
    assign hzIf.idUseRt = useRt;
    assign hzIf.exRs = deRs;
    assign hzIf.exRt = deRt;
    assign hzIf.exRd = deRd;
    assign hzIf.exMemRead = deCtrl.memRead;
    assign hzIf.memRd = emRd;
    assign hzIf.memRegWrite = emCtrl.regWrite;
    assign hzIf.wbRd = mwRd;
    assign hzIf.wbRegWrite = mwCtrl.regWrite;
    assign stall = hzIf.stall;

    hazardUnit u_hazardUnit (
        .hz(hzIf)
    );

    // Execute
    assign fwdA = (hzIf.forwardA == fwdMem) ? emAluOut
                : (hzIf.forwardA == fwdWb) ? wbData : deRead1;
    assign fwdB = (hzIf.forwardB == fwdMem) ? emAluOut
                : (hzIf.forwardB == fwdWb) ? wbData : deRead2;
    assign aluInA = deCtrl.isLink ? dePcNext : fwdA;
    assign aluInB = deCtrl.aluSrc ? deImm : fwdB;
    assign branchTarget = dePcNext + deImm;

    alu u_alu (
        .ctrl       (deCtrl),
        .opcode     (deOpcode),
        .func       (deFunc),
        .operandA   (aluInA),
        .operandB   (aluInB),
        .result     (aluResult),
        .branchTaken(branchTaken)
    );

    assign exBranch = deValid && deCtrl.isBranch && branchTaken;
    assign exJumpR = deValid && deCtrl.isJumpR;
    assign idJump = fdValid && ctrl.isJump;

    assign pcPlus1 = pc + wordWidth'(1);

    always_comb begin
        if (stall)
            nextPc = pc;
        else if (exBranch)
            nextPc = branchTarget;
        else if (exJumpR)
            nextPc = fwdA;
        else if (idJump)
            nextPc = jumpTarget;
        else
            nextPc = pcPlus1;
    end

    // Memory ports
    assign instAddr = pc;
    assign instRead = !halted;
    assign dataAddr = emAluOut;
    assign dataRead = emCtrl.memRead;
    assign dataWrite = emCtrl.memWrite;
    assign dataWdata = emStoreData;

    assign wbData = mwCtrl.memToReg ? mwReadData : mwAluOut;

    // HLT heading for writeback keeps the next instruction out of memory
    assign emHalt = emValid && emCtrl.isHalt;
    assign retireHalt = mwValid && mwCtrl.isHalt;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
            fdValid <= 1'b0;
            deValid <= 1'b0;
            deCtrl <= '0;
            emValid <= 1'b0;
            emCtrl <= '0;
            mwValid <= 1'b0;
            mwCtrl <= '0;
            halted <= 1'b0;
            numInst <= '0;
            outPort <= '0;
        end else if (retireHalt) begin
            halted <= 1'b1;
            numInst <= numInst + wordWidth'(1);
            fdValid <= 1'b0;
            deValid <= 1'b0;
            deCtrl <= '0;
            emValid <= 1'b0;
            emCtrl <= '0;
            mwValid <= 1'b0;
            mwCtrl <= '0;
        end else if (!halted) begin
            pc <= nextPc;
            if (!stall) begin
                fdValid <= !(exBranch || exJumpR || idJump);
            end
            if (stall || exBranch || exJumpR) begin
                deValid <= 1'b0;
                deCtrl <= '0;
            end else begin
                deValid <= fdValid;
                deCtrl <= ctrl;
            end
            emValid <= deValid && !emHalt;
            emCtrl <= emHalt ? '0 : deCtrl;
            mwValid <= emValid;
            mwCtrl <= emCtrl;
            if (mwValid) begin
                numInst <= numInst + wordWidth'(1);
                if (mwCtrl.isWwd) begin
                    outPort <= mwAluOut;
                end
            end
        end
    end

    // Payload follows the bubble bits above
    always_ff @(posedge Clk) begin
        if (!stall) begin
            fdInstr <= instData;
            fdPcNext <= pcPlus1;
        end
        dePcNext <= fdPcNext;
        deRead1 <= idRead1;
        deRead2 <= idRead2;
        deImm <= idImm;
        deRs <= idRs;
        deRt <= idRt;
        deRd <= idRd;
        deOpcode <= idOpcode;
        deFunc <= funcE'(fdInstr[5:0]);
        emAluOut <= aluResult;
        emStoreData <= fwdB;
        emRd <= deRd;
        mwAluOut <= emAluOut;
        mwReadData <= dataRdata;
        mwRd <= emRd;
    end

endmodule

/* hw/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop (
    input  logic                         Clk,
    input  logic                         arstN,
    input  logic [cpuPkg::wordWidth-1:0] instData,
    input  logic [cpuPkg::wordWidth-1:0] dataRdata,
    output logic [cpuPkg::wordWidth-1:0] instAddr,
    output logic                         instRead,
    output logic [cpuPkg::wordWidth-1:0] dataAddr,
    output logic                         dataRead,
    output logic                         dataWrite,
    output logic [cpuPkg::wordWidth-1:0] dataWdata,
    output logic                         halted,
    output logic [cpuPkg::wordWidth-1:0] numInst,
    output logic [cpuPkg::wordWidth-1:0] outPort
);
    import cpuPkg::*;

    ctrlT                 ctrl;
    logic                 useRs;
    logic                 useRt;
    logic [wordWidth-1:0] decodeInstr;
    logic                 decodeValid;

    controlUnit u_controlUnit (
        .instr      (decodeInstr),
        .decodeValid(decodeValid),
        .ctrl       (ctrl),
        .useRs      (useRs),
        .useRt      (useRt)
    );

    pipeDatapath u_pipeDatapath (
        .Clk        (Clk),
        .arstN      (arstN),
        .instData   (instData),
        .dataRdata  (dataRdata),
        .ctrl       (ctrl),
        .useRs      (useRs),
        .useRt      (useRt),
        .instAddr   (instAddr),
        .instRead   (instRead),
        .dataAddr   (dataAddr),
        .dataRead   (dataRead),
        .dataWrite  (dataWrite),
        .dataWdata  (dataWdata),
        .decodeInstr(decodeInstr),
        .decodeValid(decodeValid),
        .halted     (halted),
        .numInst    (numInst),
        .outPort    (outPort)
    );

endmodule

/* testbench/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
    output logic Clk,
    output logic arstN
);
    localparam time halfPeriod = 20ns;

    initial begin
        Clk = 1'b0;
        forever #(halfPeriod) Clk = ~Clk;
    end

    // Reset held for ten rising edges
    initial begin
        arstN = 1'b0;
        repeat (10) @(posedge Clk);
        arstN <= 1'b1;
    end

endmodule

/* testbench/cpu_assertions.sv */
`timescale 1ns/1ps

module cpuAssertions (
    input logic        Clk,
    input logic        arstN,
    input logic        dataRead,
    input logic        dataWrite,
    input logic        halted,
    input logic        instRead,
    input logic [15:0] instAddr
);

    noReadWrite: assert property (@(posedge Clk) disable iff (!arstN)
        !(dataRead && dataWrite))
        else $error("dataRead and dataWrite high together");

    haltSticky: assert property (@(posedge Clk) disable iff (!arstN)
        halted |=> halted)
        else $error("halted fell without reset");

    // Fetch is off and the PC frozen once halted
    noFetchWhenHalted: assert property (@(posedge Clk) disable iff (!arstN)
        halted |-> !instRead && $stable(instAddr))
        else $error("fetch still active while halted");

endmodule

bind pipeDatapath cpuAssertions u_cpuAssertions (
    .Clk      (Clk),
    .arstN    (arstN),
    .dataRead (dataRead),
    .dataWrite(dataWrite),
    .halted   (halted),
    .instRead (instRead),
    .instAddr (instAddr)
);

/* testbench/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;
    localparam int memWords = 65536;
    localparam int clkPeriodNs = 40;

    logic        Clk;
    logic        arstN;
    logic [15:0] instData;
    logic [15:0] dataRdata;
    logic [15:0] instAddr;
    logic        instRead;
    logic [15:0] dataAddr;
    logic        dataRead;
    logic        dataWrite;
    logic [15:0] dataWdata;
    logic        halted;
    logic [15:0] numInst;
    logic [15:0] outPort;

    logic [15:0] imem [memWords];
    logic [15:0] dmem [memWords];

    logic [15:0] expOut [$];
    logic [15:0] expStoreAddr [$];
    logic [15:0] expStoreData [$];
    logic [15:0] expRetired;
    logic [15:0] lastOut;
    int          progCount;
    logic        loaded;

    tbClock u_tbClock (
        .Clk  (Clk),
        .arstN(arstN)
    );

    cpuTop u_cpuTop (
        .Clk      (Clk),
        .arstN    (arstN),
        .instData (instData),
        .dataRdata(dataRdata),
        .instAddr (instAddr),
        .instRead (instRead),
        .dataAddr (dataAddr),
        .dataRead (dataRead),
        .dataWrite(dataWrite),
        .dataWdata(dataWdata),
        .halted   (halted),
        .numInst  (numInst),
        .outPort  (outPort)
    );

    // Both memories answer in the same cycle
    assign instData = imem[instAddr];
    // Data port gives the inverted word unless a read is requested
    assign dataRdata = dataRead ? dmem[dataAddr] : ~dmem[dataAddr];

    always @(posedge Clk) begin
        if (dataWrite) begin
            dmem[dataAddr] <= dataWdata;
        end
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s actual %h expected %h",
                     $time, name, actual, expected);
            failRun("Value check failed");
        end
    endtask

    task automatic loadProgram();
        int          fd;
        int          code;
        logic [7:0]  tag;
        logic [15:0] first;
        logic [15:0] second;
        string       rest;
        for (int a = 0; a < memWords; a++) begin
            imem[a] = 16'(a) ^ 16'h5A5A;
            dmem[a] = 16'(a) ^ 16'hA5A5;
        end
        fd = $fopen("testbench/programInput.txt", "r");
        if (fd == 0) begin
            failRun("Could not open testbench/programInput.txt");
        end else begin
            progCount = 0;
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", tag);
                if (code != 1) begin
                    break;
                end
                case (tag)
                    "#": code = $fgets(rest, fd);
                    "P": begin
                        code = $fscanf(fd, "%h", first);
                        imem[progCount] = first;
                        progCount++;
                    end
                    "D": begin
                        code = $fscanf(fd, "%h %h", first, second);
                        dmem[first] = second;
                    end
                    "O": begin
                        code = $fscanf(fd, "%h", first);
                        expOut.push_back(first);
                    end
                    "S": begin
                        code = $fscanf(fd, "%h %h", first, second);
                        expStoreAddr.push_back(first);
                        expStoreData.push_back(second);
                    end
                    "N": code = $fscanf(fd, "%h", expRetired);
                    default: failRun($sformatf("Unknown tag %c in program file", tag));
                endcase
            end
            $fclose(fd);
        end
    endtask

    // Every outPort change and every store is matched in order
    always @(negedge Clk) begin
        if (arstN && loaded) begin
            if (outPort !== lastOut) begin
                if (expOut.size() == 0) begin
                    failRun($sformatf("outPort changed to %h with no output expected",
                                      outPort));
                end else begin
                    checkValue("outPort", outPort, expOut.pop_front());
                    lastOut = outPort;
                end
            end
            if (dataWrite) begin
                if (expStoreAddr.size() == 0) begin
                    failRun($sformatf("Unexpected store of %h to address %h",
                                      dataWdata, dataAddr));
                end else begin
                    checkValue("dataAddr", dataAddr, expStoreAddr.pop_front());
                    checkValue("dataWdata", dataWdata, expStoreData.pop_front());
                end
            end
        end
    end

    initial begin
        wait (loaded);
        #(clkPeriodNs * (20 + 8 * progCount) * 1ns);
        failRun("Timeout: the processor never halted");
    end

    initial begin
        loaded = 1'b0;
        lastOut = '0;
        expRetired = '0;
        loadProgram();
        loaded = 1'b1;
        wait (arstN);
        @(negedge Clk);
        // Out of reset the data port is idle and fetch is on
        checkValue("dataRead", {15'd0, dataRead}, 16'd0);
        checkValue("instRead", {15'd0, instRead}, 16'd1);
        wait (halted);
        @(negedge Clk);
        checkValue("instRead", {15'd0, instRead}, 16'd0);
        checkValue("numInst", numInst, expRetired);
        // Core must stay frozen
        repeat (10) @(negedge Clk);
        checkValue("halted", {15'd0, halted}, 16'd1);
        checkValue("numInst", numInst, expRetired);
        if (expOut.size() != 0 || expStoreAddr.size() != 0) begin
            failRun($sformatf("Run ended with %0d outputs and %0d stores still expected",
                              expOut.size(), expStoreAddr.size()));
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

/* testbench/programInput.txt */
# P word | D addr value | O outPort value | S store addr value | N retire count
# All values in hex
D 0020 BEEF
D 0021 0777
P 6112
P 5534
P F41C
P 4205
P 43FD
P FB00
P F01C
P FB41
P F603
P F01C
P FD02
P F004
P F01C
P FC45
P F41C
P 461D
P 7800
P F01C
P 7B01
P FC40
P 8902
P 7802
P F01C
P 1102
P F81C
P 8A00
P 0102
P FC1C
P 901F
P F81C
P F81C
P A028
P 4A10
P F81C
P 2C02
P F81C
P F81C
P 3C01
P 49FC
P F41A
P F81C
P F819
P FC1C
P FC1C
P F81C
P FEC0
P 8B01
P FC1C
P F01D
P F41C
P 8500
P F01C
O 1234
O 0002
O 000D
O FFF7
O 0003
O BEEF
O C666
O 0777
O 0020
O 0030
O 0028
O 079F
S 0022 C666
S 0029 079F
N 0029

/* compile.f */
hw/cpuPkg.sv
hw/hazardIf.sv
hw/regFile.sv
hw/alu.sv
hw/hazardUnit.sv
hw/controlUnit.sv
hw/pipeDatapath.sv
hw/cpuTop.sv
testbench/tbClock.sv
testbench/cpu_assertions.sv
testbench/cpuTb.sv

/* run.sh */
#!/bin/sh
# Build and run from the project root
verilator --binary --assert --timing -Wno-fatal --top-module cpuTb \
    -f compile.f -o cpuSim || { echo "Build failed"; exit 1; }
./obj_dir/cpuSim > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log && echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}
